/* design/opPath_cfg.svh */
`ifndef OP_PATH_CFG_SVH
`define OP_PATH_CFG_SVH

// Width of a data or address word
`define OP_DATA_W 32

// Width of a register number, r0 to r15
`define OP_REG_W 4

// Cycles from the issue edge until the outputs show the instruction
`define OP_LATENCY 2

`endif

/* design/opPathPkg.sv */
`include "opPath_cfg.svh"

package opPathPkg;

	typedef logic [`OP_DATA_W-1:0] word_t;
	typedef logic [`OP_REG_W-1:0]  regIdx_t;
	typedef logic [4:0]            shiftAmt_t;
	typedef logic [3:0]            flags_t;      // N Z C V from the high bit down
	typedef logic [3:0]            aluOp_t;      // ir[24:21]
	typedef logic [2:0]            instrClass_t; // ir[27:25]

	localparam instrClass_t CLS_DP_REG = 3'b000; // Shift by immediate, or mode 3 when ir[4] set
	localparam instrClass_t CLS_DP_IMM = 3'b001; // Rotated 8-bit immediate
	localparam instrClass_t CLS_MODE2  = 3'b010; // 12-bit offset
	localparam instrClass_t CLS_LSM    = 3'b100; // Load/store multiple
	localparam instrClass_t CLS_BRANCH = 3'b101; // B and BL

	localparam aluOp_t OP_AND = 4'h0;
	localparam aluOp_t OP_EOR = 4'h1;
	localparam aluOp_t OP_SUB = 4'h2;
	localparam aluOp_t OP_RSB = 4'h3;
	localparam aluOp_t OP_ADD = 4'h4;
	localparam aluOp_t OP_ADC = 4'h5;
	localparam aluOp_t OP_SBC = 4'h6;
	localparam aluOp_t OP_RSC = 4'h7;
	localparam aluOp_t OP_TST = 4'h8;
	localparam aluOp_t OP_TEQ = 4'h9;
	localparam aluOp_t OP_CMP = 4'hA;
	localparam aluOp_t OP_CMN = 4'hB;
	localparam aluOp_t OP_ORR = 4'hC;
	localparam aluOp_t OP_MOV = 4'hD;
	localparam aluOp_t OP_BIC = 4'hE;
	localparam aluOp_t OP_MVN = 4'hF;

endpackage

/* design/opBus.sv */
`timescale 1ns/1ps

// Latched instruction and operands, from the input latch to the ALU stage
interface opBus;

	opPathPkg::word_t ir;
	opPathPkg::word_t rm;
	opPathPkg::word_t rn;
	opPathPkg::word_t pc;
	logic             valid; // High for one cycle per issued instruction

	modport source (output ir, rm, rn, pc, valid);
	modport sink   (input  ir, rm, rn, pc, valid);

endinterface

// Execute results, from the ALU stage to the result router
interface resBus;

	opPathPkg::word_t   result;   // ALU result, address or branch target
	opPathPkg::regIdx_t dest;     // rd, or r14 for branch and link
	logic               writeReg; // Register write wanted
	logic               isAddr;   // Memory class
	logic               isBranch; // Branch class
	opPathPkg::word_t   linkData; // Return address for BL

	modport source (output result, dest, writeReg, isAddr, isBranch, linkData);
	modport sink   (input  result, dest, writeReg, isAddr, isBranch, linkData);

endinterface

/* design/instrLatch.sv */
`timescale 1ns/1ps

module instrLatch
(
	input  logic             clk,
	input  logic             reset,
	input  logic             issue,
	input  opPathPkg::word_t ir,
	input  opPathPkg::word_t rm,
	input  opPathPkg::word_t rn,
	input  opPathPkg::word_t pc,
	opBus.source             bus
);

	always_ff @(posedge clk)
	begin
		if (reset)
			bus.valid <= 1'b0;
		else
			bus.valid <= issue; // One-cycle strobe per instruction
	end

	// Operands only move on issue so the datapath stays quiet when idle
	always_ff @(posedge clk)
	begin
		if (issue)
		begin
			bus.ir <= ir;
			bus.rm <= rm;
			bus.rn <= rn;
			bus.pc <= pc;
		end
	end

endmodule

/* design/operandShifter.sv */
`timescale 1ns/1ps
`include "opPath_cfg.svh"

module operandShifter
(
	input  opPathPkg::word_t ir,
	input  opPathPkg::word_t rm,
	input  logic             carryIn,
	output opPathPkg::word_t shifterOperand,
	output logic             carryOut
);

	opPathPkg::instrClass_t  instrClass;
	opPathPkg::shiftAmt_t    shiftAmt;  // Immediate shift amount
	opPathPkg::shiftAmt_t    rotAmt;    // Twice the rotate field
	logic [5:0]              longAmt;   // Amount 0 stands for 32 on LSR and ASR
	logic [`OP_DATA_W:0]     wide;      // Extra bit catches the shifted-out carry
	logic [2*`OP_DATA_W-1:0] doubled;   // Two copies side by side for rotates
	logic [4:0]              listCount; // Registers named in the list

	assign instrClass = ir[27:25];
	assign shiftAmt   = ir[11:7];
	assign rotAmt     = {ir[11:8], 1'b0};
	assign longAmt    = {shiftAmt == '0, shiftAmt};

	always_comb
	begin
		listCount = '0;
		for (int i = 0; i < 16; i++)
			listCount = listCount + 5'(ir[i]);
	end

	always_comb
	begin
		shifterOperand = '0;
		carryOut       = carryIn; // Non-shifting classes keep C
		wide           = '0;
		doubled        = '0;
		case (instrClass)
			opPathPkg::CLS_DP_IMM:
			begin
				doubled        = {24'd0, ir[7:0], 24'd0, ir[7:0]} >> rotAmt;
				shifterOperand = doubled[`OP_DATA_W-1:0];
				if (rotAmt != '0)
					carryOut = shifterOperand[`OP_DATA_W-1];
			end
			opPathPkg::CLS_DP_REG:
			begin
				if (ir[4])
					shifterOperand = {24'd0, ir[11:8], ir[3:0]}; // Mode 3 split offset
				else
				begin
					case (ir[6:5])
						2'b00: // LSL, amount 0 passes Rm and C
						begin
							wide           = {1'b0, rm} << shiftAmt;
							shifterOperand = wide[`OP_DATA_W-1:0];
							if (shiftAmt != '0)
								carryOut = wide[`OP_DATA_W];
						end
						2'b01: // LSR
						begin
							wide           = {rm, 1'b0} >> longAmt;
							shifterOperand = wide[`OP_DATA_W:1];
							carryOut       = wide[0];
						end
						2'b10: // ASR
						begin
							wide           = $signed({rm, 1'b0}) >>> longAmt;
							shifterOperand = wide[`OP_DATA_W:1];
							carryOut       = wide[0];
						end
						default: // ROR, amount 0 is RRX
						begin
							if (shiftAmt == '0)
							begin
								shifterOperand = {carryIn, rm[`OP_DATA_W-1:1]};
								carryOut       = rm[0];
							end
							else
							begin
								doubled        = {rm, rm} >> shiftAmt;
								shifterOperand = doubled[`OP_DATA_W-1:0];
								carryOut       = shifterOperand[`OP_DATA_W-1];
							end
						end
					endcase
				end
			end
			opPathPkg::CLS_MODE2:
				shifterOperand = {20'd0, ir[11:0]};
			opPathPkg::CLS_LSM:
				shifterOperand = {25'd0, listCount, 2'b00}; // Four bytes per register
			opPathPkg::CLS_BRANCH:
				shifterOperand = {{6{ir[23]}}, ir[23:0], 2'b00};
			default:
				shifterOperand = '0;
		endcase
	end

endmodule

/* design/operandAlu.sv */
`timescale 1ns/1ps
`include "opPath_cfg.svh"

module operandAlu
(
	input  logic              clk,
	input  logic              reset,
	opBus.sink                src,
	resBus.source             dst,
	output opPathPkg::flags_t flags
);

	opPathPkg::instrClass_t instrClass;
	opPathPkg::aluOp_t      aluOp;
	opPathPkg::word_t       shifterOperand;
	logic                   shiftCarry;
	logic                   dpClass;
	logic                   memClass;
	logic                   brClass;
	logic                   isTest;   // TST, TEQ, CMP, CMN
	logic                   isArith;
	logic                   reverse;  // RSB and RSC swap the operands
	logic                   invert;   // Subtract by adding the complement
	logic                   addCin;
	opPathPkg::word_t       addA;
	opPathPkg::word_t       addB;
	logic [`OP_DATA_W:0]    sum;
	opPathPkg::word_t       logicRes;
	opPathPkg::word_t       aluRes;
	opPathPkg::word_t       memAddr;
	logic                   overflow;

	operandShifter shifter (.ir(src.ir), .rm(src.rm), .carryIn(flags[1]),
		.shifterOperand(shifterOperand), .carryOut(shiftCarry));

	assign instrClass = src.ir[27:25];
	assign aluOp      = src.ir[24:21];
	assign dpClass    = (instrClass == opPathPkg::CLS_DP_REG && !src.ir[4]) ||
		instrClass == opPathPkg::CLS_DP_IMM;
	assign memClass   = (instrClass == opPathPkg::CLS_DP_REG && src.ir[4]) ||
		instrClass == opPathPkg::CLS_MODE2 || instrClass == opPathPkg::CLS_LSM;
	assign brClass    = instrClass == opPathPkg::CLS_BRANCH;
	assign isTest     = aluOp inside {opPathPkg::OP_TST, opPathPkg::OP_TEQ,
		opPathPkg::OP_CMP, opPathPkg::OP_CMN};

	always_comb
	begin
		isArith  = 1'b0;
		reverse  = 1'b0;
		invert   = 1'b0;
		addCin   = 1'b0;
		logicRes = '0;
		case (aluOp)
			opPathPkg::OP_AND, opPathPkg::OP_TST: logicRes = src.rn & shifterOperand;
			opPathPkg::OP_EOR, opPathPkg::OP_TEQ: logicRes = src.rn ^ shifterOperand;
			opPathPkg::OP_ORR: logicRes = src.rn | shifterOperand;
			opPathPkg::OP_MOV: logicRes = shifterOperand;
			opPathPkg::OP_BIC: logicRes = src.rn & ~shifterOperand;
			opPathPkg::OP_MVN: logicRes = ~shifterOperand;
			default: isArith = 1'b1;
		endcase
		case (aluOp)
			opPathPkg::OP_ADD, opPathPkg::OP_CMN: addCin = 1'b0;
			opPathPkg::OP_SUB, opPathPkg::OP_CMP: {invert, addCin} = 2'b11;
			opPathPkg::OP_RSB: {reverse, invert, addCin} = 3'b111;
			opPathPkg::OP_ADC: addCin = flags[1];
			opPathPkg::OP_SBC: {invert, addCin} = {1'b1, flags[1]}; // Borrow is not C
			opPathPkg::OP_RSC: {reverse, invert, addCin} = {2'b11, flags[1]};
			default: addCin = 1'b0;
		endcase
	end

	assign addA     = reverse ? shifterOperand : src.rn;
	assign addB     = (reverse ? src.rn : shifterOperand) ^ {`OP_DATA_W{invert}};
	assign sum      = {1'b0, addA} + {1'b0, addB} + addCin;
	assign overflow = addA[`OP_DATA_W-1] == addB[`OP_DATA_W-1] &&
		sum[`OP_DATA_W-1] != addA[`OP_DATA_W-1];
	assign aluRes   = isArith ? sum[`OP_DATA_W-1:0] : logicRes;
	assign memAddr  = src.ir[23] ? src.rn + shifterOperand : src.rn - shifterOperand;

	// Logical ops take C from the shifter and leave V alone
	always_ff @(posedge clk)
	begin
		if (reset)
			flags <= '0;
		else if (src.valid && dpClass && (src.ir[20] || isTest))
			flags <= {aluRes[`OP_DATA_W-1], aluRes == '0, isArith ? sum[`OP_DATA_W] : shiftCarry,
				isArith ? overflow : flags[0]};
	end

	assign dst.result   = dpClass ? aluRes : (memClass ? memAddr : src.pc + 8 + shifterOperand);
	assign dst.dest     = brClass ? opPathPkg::regIdx_t'(14) : src.ir[15:12]; // r14 for BL
	assign dst.writeReg = src.valid && ((dpClass && !isTest) || (brClass && src.ir[24]));
	assign dst.isAddr   = src.valid && memClass;
	assign dst.isBranch = src.valid && brClass;
	assign dst.linkData = src.pc + 4;

endmodule

/* design/resultRouter.sv */
`timescale 1ns/1ps

module resultRouter
(
	input  logic               clk,
	input  logic               reset,
	resBus.sink                src,
	output logic               regWe,
	output opPathPkg::regIdx_t regIdx,
	output opPathPkg::word_t   regData,
	output logic               addrValid,
	output opPathPkg::word_t   addr,
	output logic               branchTaken,
	output opPathPkg::word_t   branchTarget
);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			regWe        <= 1'b0;
			regIdx       <= '0;
			regData      <= '0;
			addrValid    <= 1'b0;
			addr         <= '0;
			branchTaken  <= 1'b0;
			branchTarget <= '0;
		end
		else
		begin
			regWe       <= src.writeReg; // Strobes last a single cycle
			addrValid   <= src.isAddr;
			branchTaken <= src.isBranch;
			if (src.writeReg)
			begin
				regIdx  <= src.dest;
				regData <= src.isBranch ? src.linkData : src.result; // BL writes the link
			end
			if (src.isAddr)
				addr <= src.result;
			if (src.isBranch)
				branchTarget <= src.result;
		end
	end

endmodule

/* design/armOperandPath.sv */
`timescale 1ns/1ps

module armOperandPath
(
	input  logic               clk,
	input  logic               reset,
	input  logic               issue,
	input  opPathPkg::word_t   ir,
	input  opPathPkg::word_t   rm,
	input  opPathPkg::word_t   rn,
	input  opPathPkg::word_t   pc,
	output logic               regWe,
	output opPathPkg::regIdx_t regIdx,
	output opPathPkg::word_t   regData,
	output logic               addrValid,
	output opPathPkg::word_t   addr,
	output logic               branchTaken,
	output opPathPkg::word_t   branchTarget,
	output opPathPkg::flags_t  flags
);

	opBus  opIf ();  // Latch to execute
	resBus resIf (); // Execute to router

	instrLatch latchStage (.clk(clk), .reset(reset), .issue(issue), .ir(ir), .rm(rm),
		.rn(rn), .pc(pc), .bus(opIf));

	operandAlu aluStage (.clk(clk), .reset(reset), .src(opIf), .dst(resIf), .flags(flags));

	resultRouter routerStage
	(
		.clk(clk),
		.reset(reset),
		.src(resIf),
		.regWe(regWe),
		.regIdx(regIdx),
		.regData(regData),
		.addrValid(addrValid),
		.addr(addr),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget)
	);

endmodule

/* sim/opPathTb_assertions.sv */
`timescale 1ns/1ps
`include "opPath_cfg.svh"

module opPathTb_assertions
(
	input logic             clk,
	input logic             reset,
	input logic             issue,
	input opPathPkg::word_t ir,
	input logic             regWe,
	input logic             addrValid,
	input logic             branchTaken
);

	logic dpClass;
	logic makesStrobe; // Supported class that is not TST, TEQ, CMP or CMN
	int   failCount = 0; // Assertion failures so far

	assign dpClass     = ir[27:25] == 3'b001 || (ir[27:25] == 3'b000 && !ir[4]);
	assign makesStrobe = ir[27:25] inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101} &&
		!(dpClass && ir[24:23] == 2'b10);

	strobesLowAfterReset: assert property (@(posedge clk)
		reset |=> !(regWe || addrValid || branchTaken))
		else
		begin
			$error("output strobe high in the cycle after reset");
			failCount++;
		end

	addrOrBranch: assert property (@(posedge clk) disable iff (reset)
		!(addrValid && branchTaken))
		else
		begin
			$error("addrValid and branchTaken high together");
			failCount++;
		end

	// BL raises regWe beside branchTaken, so that pair counts as one event
	oneStrobePerIssue: assert property (@(posedge clk) disable iff (reset)
		issue && makesStrobe |-> ##`OP_LATENCY
		$onehot({addrValid, branchTaken, regWe && !branchTaken}))
		else
		begin
			$error("issued instruction did not give exactly one strobe");
			failCount++;
		end

endmodule

bind armOperandPath opPathTb_assertions checks (.clk(clk), .reset(reset), .issue(issue),
	.ir(ir), .regWe(regWe), .addrValid(addrValid), .branchTaken(branchTaken));

/* sim/opPathTb.sv */
`timescale 1ns/1ps
`include "opPath_cfg.svh"

module opPathTb;

	typedef struct packed {
		logic               regWe;
		logic               addrValid;
		logic               branchTaken;
		opPathPkg::regIdx_t regIdx;
		opPathPkg::word_t   regData;
		opPathPkg::word_t   addr;
		opPathPkg::word_t   branchTarget;
		opPathPkg::flags_t  flags; // Flags after this instruction
	} expect_t;

	localparam int NUM_INSTR  = 800;
	localparam int NUM_CYCLES = NUM_INSTR + `OP_LATENCY + 6; // Reset and flush included

	logic               clk = 1'b0;
	logic               reset;
	logic               issue;
	opPathPkg::word_t   ir;
	opPathPkg::word_t   rm;
	opPathPkg::word_t   rn;
	opPathPkg::word_t   pc;
	logic               regWe;
	opPathPkg::regIdx_t regIdx;
	opPathPkg::word_t   regData;
	logic               addrValid;
	opPathPkg::word_t   addr;
	logic               branchTaken;
	opPathPkg::word_t   branchTarget;
	opPathPkg::flags_t  flags;
	int                 seed;
	opPathPkg::flags_t  modelFlags;
	expect_t            expQ[$]; // One entry per sampled rising edge

	armOperandPath i_armOperandPath (.clk(clk), .reset(reset), .issue(issue), .ir(ir),
		.rm(rm), .rn(rn), .pc(pc), .regWe(regWe), .regIdx(regIdx), .regData(regData),
		.addrValid(addrValid), .addr(addr), .branchTaken(branchTaken),
		.branchTarget(branchTarget), .flags(flags));

	always #10 clk = ~clk;

	task automatic abortRun(string msg);
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic checkWord(string name, opPathPkg::word_t got, opPathPkg::word_t exp);
		if (got !== exp)
			abortRun($sformatf("ERR %0t ns %s is %h, expected %h", $time, name, got, exp));
	endtask

	task automatic checkFlags(string name, opPathPkg::flags_t got, opPathPkg::flags_t exp);
		if (got !== exp)
			abortRun($sformatf("ERR %0t ns %s NZCV is %b, expected %b", $time, name, got, exp));
	endtask

	task automatic checkReg(string name, opPathPkg::regIdx_t got, opPathPkg::regIdx_t exp);
		if (got !== exp)
			abortRun($sformatf("ERR %0t ns %s is r%0d, expected r%0d", $time, name, got, exp));
	endtask

	task automatic checkBit(string name, logic got, logic exp);
		if (got !== exp)
			abortRun($sformatf("ERR %0t ns %s is %b, expected %b", $time, name, got, exp));
	endtask

	function automatic opPathPkg::word_t rotr(opPathPkg::word_t x, int amt);
		return (x >> amt) | (x << (32 - amt)); // Amount 0 leaves x as it is
	endfunction

	// Add or subtract with carry, cin high means no borrow on a subtract
	function automatic void addSub(input opPathPkg::word_t a, input opPathPkg::word_t b,
		input logic sub, input logic cin, output opPathPkg::word_t res, output logic c,
		output logic v);
		longint u;
		longint s;
		if (sub)
		begin
			u = longint'(a) - longint'(b) - longint'(!cin);
			s = longint'($signed(a)) - longint'($signed(b)) - longint'(!cin);
			c = u >= 0;
		end
		else
		begin
			u = longint'(a) + longint'(b) + longint'(cin);
			s = longint'($signed(a)) + longint'($signed(b)) + longint'(cin);
			c = u > 64'hFFFF_FFFF;
		end
		res = u[31:0];
		v   = s > 64'sd2147483647 || s < -64'sd2147483648;
	endfunction

	function automatic expect_t opModel(opPathPkg::word_t i, opPathPkg::word_t r,
		opPathPkg::word_t n, opPathPkg::word_t p, opPathPkg::flags_t fl, logic iss);
		expect_t          e;
		opPathPkg::word_t so;
		opPathPkg::word_t res;
		logic             sc;
		logic             c;
		logic             v;
		logic             dp;
		int               amt;
		e       = '0;
		e.flags = fl;
		so      = '0;
		res     = '0;
		sc      = fl[1];
		amt     = i[11:7];
		dp      = i[27:25] == opPathPkg::CLS_DP_IMM || (i[27:25] == opPathPkg::CLS_DP_REG && !i[4]);
		if (!iss)
			return e;
		case (i[27:25])
			opPathPkg::CLS_DP_IMM:
			begin
				so = rotr(32'(i[7:0]), 2 * i[11:8]);
				if (i[11:8] != 0)
					sc = so[31];
			end
			opPathPkg::CLS_DP_REG:
				if (i[4])
					so = {i[11:8], i[3:0]}; // Mode 3 offset
				else if (i[6:5] == 2'b00)
				begin
					so = r << amt;
					sc = (amt == 0) ? fl[1] : r[32 - amt];
				end
				else if (i[6:5] == 2'b11)
				begin
					so = (amt == 0) ? {fl[1], r[31:1]} : rotr(r, amt); // RRX at 0
					sc = (amt == 0) ? r[0] : r[amt - 1];
				end
				else
				begin
					amt = (amt == 0) ? 32 : amt;
					so  = (i[6:5] == 2'b01) ? r >> amt :
						((amt == 32) ? {32{r[31]}} : opPathPkg::word_t'($signed(r) >>> amt));
					sc  = r[amt - 1];
				end
			opPathPkg::CLS_MODE2:  so = i[11:0];
			opPathPkg::CLS_LSM:    so = 4 * $countones(i[15:0]);
			opPathPkg::CLS_BRANCH: so = 32'($signed(i[23:0])) << 2;
			default:               return e; // Unsupported, nothing comes out
		endcase
		if (dp)
		begin
			c = sc;
			v = fl[0];
			case (i[24:21])
				opPathPkg::OP_AND, opPathPkg::OP_TST: res = n & so;
				opPathPkg::OP_EOR, opPathPkg::OP_TEQ: res = n ^ so;
				opPathPkg::OP_SUB, opPathPkg::OP_CMP: addSub(n, so, 1'b1, 1'b1, res, c, v);
				opPathPkg::OP_RSB: addSub(so, n, 1'b1, 1'b1, res, c, v);
				opPathPkg::OP_ADD, opPathPkg::OP_CMN: addSub(n, so, 1'b0, 1'b0, res, c, v);
				opPathPkg::OP_ADC: addSub(n, so, 1'b0, fl[1], res, c, v);
				opPathPkg::OP_SBC: addSub(n, so, 1'b1, fl[1], res, c, v);
				opPathPkg::OP_RSC: addSub(so, n, 1'b1, fl[1], res, c, v);
				opPathPkg::OP_ORR: res = n | so;
				opPathPkg::OP_MOV: res = so;
				opPathPkg::OP_BIC: res = n & ~so;
				default:           res = ~so;
			endcase
			if (i[20] || i[24:23] == 2'b10)
				e.flags = {res[31], res == 0, c, v};
			e.regWe   = i[24:23] != 2'b10; // Test ops write nothing
			e.regIdx  = i[15:12];
			e.regData = res;
		end
		else if (i[27:25] == opPathPkg::CLS_BRANCH)
		begin
			e.branchTaken  = 1'b1;
			e.branchTarget = p + 8 + so;
			e.regWe        = i[24];
			e.regIdx       = 4'd14;
			e.regData      = p + 4;
		end
		else
		begin
			e.addrValid = 1'b1;
			e.addr      = i[23] ? n + so : n - so;
		end
		return e;
	endfunction

	function automatic opPathPkg::word_t randInstr();
		opPathPkg::word_t w;
		int               pick;
		w    = $random(seed);
		pick = {$random(seed)} % 9;
		case (pick)
			0, 1, 2: w[27:25] = opPathPkg::CLS_DP_REG;
			3, 4:    w[27:25] = opPathPkg::CLS_DP_IMM;
			5:       w[27:25] = opPathPkg::CLS_MODE2;
			6:       w[27:25] = opPathPkg::CLS_LSM;
			7:       w[27:25] = opPathPkg::CLS_BRANCH;
			default: w[27:25] = w[0] ? 3'b011 : {2'b11, w[1]}; // Unsupported classes
		endcase
		if ({$random(seed)} % 4 == 0)
			w[11:7] = '0; // Shift amount 0 and rotate 0
		if ({$random(seed)} % 4 == 0)
			w[15:0] = w[2] ? 16'hFFFF : 16'h0000; // Full or empty register list
		return w;
	endfunction

	// Drive on the falling edge, record the expectation at the sampling edge
	task automatic nextCycle(logic rst, logic iss);
		@(negedge clk);
		reset = rst;
		issue = iss;
		ir    = randInstr();
		rm    = $random(seed);
		rn    = $random(seed);
		pc    = $random(seed) & 32'hFFFF_FFFC;
		@(posedge clk);
		if (rst)
		begin
			expQ.delete(); // In-flight work is dropped
			modelFlags = '0;
		end
		else
		begin
			expQ.push_back(opModel(ir, rm, rn, pc, modelFlags, iss));
			modelFlags = expQ[$].flags;
		end
	endtask

	task automatic compareOutputs(expect_t e, logic all);
		checkBit("regWe", regWe, e.regWe);
		checkBit("addrValid", addrValid, e.addrValid);
		checkBit("branchTaken", branchTaken, e.branchTaken);
		if (all || e.regWe)
		begin
			checkReg("regIdx", regIdx, e.regIdx);
			checkWord("regData", regData, e.regData);
		end
		if (all || e.addrValid)
			checkWord("addr", addr, e.addr);
		if (all || e.branchTaken)
			checkWord("branchTarget", branchTarget, e.branchTarget);
		checkFlags("flags", flags, e.flags);
	endtask

	initial
	begin : compare
		expect_t e;
		forever
		begin
			@(negedge clk);
			if (i_armOperandPath.checks.failCount != 0)
				abortRun("An assertion in the bound checker failed");
			if (expQ.size() == 0)
				compareOutputs('0, 1'b1); // Just out of reset
			else if (expQ.size() >= `OP_LATENCY)
			begin
				e = expQ.pop_front();
				compareOutputs(e, 1'b0);
			end
		end
	end

	initial
	begin : stimulus
		seed       = 32'h4736_651f;
		modelFlags = '0;
		reset      = 1'b1;
		issue      = 1'b0;
		ir         = '0;
		rm         = '0;
		rn         = '0;
		pc         = '0;
		nextCycle(1'b1, 1'b0);
		for (int k = 0; k < NUM_INSTR; k++)
		begin
			if (k == NUM_INSTR / 2)
			begin
				nextCycle(1'b0, 1'b1); // Caught by reset while in flight
				nextCycle(1'b1, 1'b0);
				nextCycle(1'b1, 1'b0);
			end
			nextCycle(1'b0, {$random(seed)} % 8 != 0); // Some idle cycles
		end
		repeat (`OP_LATENCY + 2)
			nextCycle(1'b0, 1'b0);
		if (i_armOperandPath.checks.failCount == 0)
		begin
			$display("TESTS PASSED");
			$finish;
		end
		else
			abortRun("An assertion in the bound checker failed");
	end

	initial
	begin : watchdog
		#(20 * NUM_CYCLES + 200);
		abortRun("Watchdog timeout, the run hung before all instructions were checked");
	end

endmodule

/* armOperandPath.f */
+incdir+design
design/opPathPkg.sv
design/opBus.sv
design/instrLatch.sv
design/operandShifter.sv
design/operandAlu.sv
design/resultRouter.sv
design/armOperandPath.sv
sim/opPathTb_assertions.sv
sim/opPathTb.sv
